// ==== list.f ====
src/insn_pkg.sv
src/ctrl_pkg.sv
src/id_stage.sv
src/id_decode.sv
src/ex_stage.sv
src/operand_select.sv
src/decode_ctrl_top.sv
+incdir+verif
verif/tb_decode_ctrl.sv

// ==== src/ctrl_pkg.sv ====
// decoded control types of the decode and execute stages
// alu, branch, load/store, write-back and operand select encodings
// execute control word and its idle value

package ctrl_pkg;

	typedef logic [4:0] alu_op_t;
	typedef logic [3:0] alu_op2_t;
	typedef logic [3:0] comp_op_t;
	typedef logic [2:0] branch_op_t;
	typedef logic [3:0] lsu_op_t;
	typedef logic [2:0] rfwb_op_t;
	typedef logic [1:0] sel_t;

	////////////////////////////////////////////////////////////////////////////
	// op encodings
	////////////////////////////////////////////////////////////////////////////

	// alu ops, register form takes them straight from bits 3..0
	localparam alu_op_t ALUOP_ADD   = 5'b0_0000;
	localparam alu_op_t ALUOP_ADDC  = 5'b0_0001;
	localparam alu_op_t ALUOP_AND   = 5'b0_0011;
	localparam alu_op_t ALUOP_OR    = 5'b0_0100;
	localparam alu_op_t ALUOP_XOR   = 5'b0_0101;
	localparam alu_op_t ALUOP_DIV   = 5'b0_1001;
	localparam alu_op_t ALUOP_DIVU  = 5'b0_1010;
	localparam alu_op_t ALUOP_FFL1  = 5'b0_1111;
	localparam alu_op_t ALUOP_MOVHI = 5'b1_0000;
	localparam alu_op_t ALUOP_COMP  = 5'b1_0001;
	// nop is an or into r0
	localparam alu_op_t ALUOP_NOP   = 5'b0_0100;

	localparam branch_op_t BRANCHOP_NOP = 3'd0;
	localparam branch_op_t BRANCHOP_J   = 3'd1;
	localparam branch_op_t BRANCHOP_JR  = 3'd2;
	localparam branch_op_t BRANCHOP_BF  = 3'd4;
	localparam branch_op_t BRANCHOP_BNF = 3'd5;
	localparam branch_op_t BRANCHOP_RFE = 3'd6;

	// bit 3 is store, bits 2..1 size, bit 0 sign extension
	localparam lsu_op_t LSUOP_NOP = 4'b0000;
	localparam lsu_op_t LSUOP_LBZ = 4'b0010;
	localparam lsu_op_t LSUOP_LBS = 4'b0011;
	localparam lsu_op_t LSUOP_LHZ = 4'b0100;
	localparam lsu_op_t LSUOP_LHS = 4'b0101;
	localparam lsu_op_t LSUOP_LWZ = 4'b0110;
	localparam lsu_op_t LSUOP_LWS = 4'b0111;
	localparam lsu_op_t LSUOP_SB  = 4'b1010;
	localparam lsu_op_t LSUOP_SH  = 4'b1100;
	localparam lsu_op_t LSUOP_SW  = 4'b1110;

	// bits 2..1 pick the source, bit 0 is the write enable
	localparam rfwb_op_t RFWB_NOP  = 3'b000;
	localparam rfwb_op_t RFWB_ALU  = 3'b001;
	localparam rfwb_op_t RFWB_LSU  = 3'b011;
	localparam rfwb_op_t RFWB_SPRS = 3'b101;
	localparam rfwb_op_t RFWB_LR   = 3'b111;

	localparam sel_t SEL_RF      = 2'd0;
	localparam sel_t SEL_IMM     = 2'd1;
	localparam sel_t SEL_EX_FORW = 2'd2;
	localparam sel_t SEL_WB_FORW = 2'd3;

	////////////////////////////////////////////////////////////////////////////
	// execute stage control word
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		alu_op_t              alu_op;
		alu_op2_t             alu_op2;
		comp_op_t             comp_op;
		rfwb_op_t             rfwb_op;
		branch_op_t           branch_op;
		insn_pkg::reg_addr_t  rf_addrw;
		insn_pkg::imm_t       simm;
		insn_pkg::pc_word_t   branch_target;
		logic                 spr_read;
		logic                 spr_write;
		logic                 illegal;
		logic                 syscall;
		logic                 trap;
	} ex_ctrl_t;

	localparam ex_ctrl_t EX_CTRL_IDLE = '{
		alu_op: ALUOP_NOP, alu_op2: '0, comp_op: '0, rfwb_op: RFWB_NOP,
		branch_op: BRANCHOP_NOP, rf_addrw: '0, simm: '0, branch_target: '0,
		spr_read: 1'b0, spr_write: 1'b0, illegal: 1'b0, syscall: 1'b0,
		trap: 1'b0
	};

endpackage

// ==== src/decode_ctrl_top.sv ====
`timescale 1ns/1ps
// decode control top level
// decode latch, decoders, execute register and operand select

module decode_ctrl_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  insn_pkg::insn_t      if_insn,
	input  insn_pkg::pc_word_t   id_pc,
	input  logic                 id_freeze,
	input  logic                 ex_freeze,
	input  logic                 wb_freeze,
	input  logic                 except_flush,
	input  logic                 pc_we,
	input  logic                 extend_flush,
	input  logic                 hw_breakpoint,
	input  logic                 wbforw_valid,
	output logic                 flushpipe,
	output insn_pkg::reg_addr_t  rf_addra,
	output insn_pkg::reg_addr_t  rf_addrb,
	output logic                 rf_rda,
	output logic                 rf_rdb,
	output insn_pkg::insn_t      id_insn,
	output insn_pkg::imm_t       id_simm,
	output ctrl_pkg::lsu_op_t    id_lsu_op,
	output ctrl_pkg::branch_op_t id_branch_op,
	output insn_pkg::pc_word_t   id_branch_target,
	output ctrl_pkg::sel_t       sel_a,
	output ctrl_pkg::sel_t       sel_b,
	output ctrl_pkg::ex_ctrl_t   ex_ctrl,
	output insn_pkg::insn_t      ex_insn
);
	import insn_pkg::*;
	import ctrl_pkg::*;

	logic      sel_imm;
	ex_ctrl_t  ex_ctrl_next;
	reg_addr_t wb_rfaddrw;

	// decode latch, produces the decode-stage word
	id_stage u_id_stage (
		.clk, .arst_n, .if_insn, .id_freeze, .except_flush, .pc_we,
		.extend_flush, .pipe_flush(flushpipe), .id_insn, .id_branch_op,
		.sel_imm, .rf_addra, .rf_addrb, .rf_rda, .rf_rdb
	);

	id_decode u_id_decode (
		.id_insn, .id_branch_op, .id_pc, .hw_breakpoint, .id_simm,
		.id_lsu_op, .id_branch_target, .ex_ctrl_next
	);

	// pipeline buffer toward execute
	ex_stage u_ex_stage (
		.clk, .arst_n, .ex_ctrl_next, .id_insn, .id_freeze, .ex_freeze,
		.wb_freeze, .pipe_flush(flushpipe), .ex_ctrl, .ex_insn, .wb_rfaddrw
	);

	operand_select u_operand_select (
		.id_insn, .sel_imm, .ex_ctrl, .wb_rfaddrw, .wbforw_valid,
		.sel_a, .sel_b
	);

endmodule

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps
// decode-to-execute control and instruction registers
// bubble insertion on decode stall or flush
// write-back copy of the write address for forwarding

module ex_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  ctrl_pkg::ex_ctrl_t  ex_ctrl_next,
	input  insn_pkg::insn_t     id_insn,
	input  logic                id_freeze,
	input  logic                ex_freeze,
	input  logic                wb_freeze,
	input  logic                pipe_flush,
	output ctrl_pkg::ex_ctrl_t  ex_ctrl,
	output insn_pkg::insn_t     ex_insn,
	output insn_pkg::reg_addr_t wb_rfaddrw
);
	import insn_pkg::*;
	import ctrl_pkg::*;

	logic bubble;

	// decode stalled while execute drains, or a flush
	// flush also overrides ex_freeze
	assign bubble = pipe_flush | (~ex_freeze & id_freeze);

	////////////////////////////////////////////////////////////////////////////
	// execute register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_ctrl <= EX_CTRL_IDLE;
			ex_insn <= NOP_INSN;
		end else if (bubble) begin
			// every field cleared, write address and target too
			ex_ctrl <= EX_CTRL_IDLE;
			ex_insn <= NOP_INSN;
		end else if (!ex_freeze) begin
			ex_ctrl <= ex_ctrl_next;
			ex_insn <= id_insn;
		end
	end

	// write address one stage on
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_rfaddrw <= '0;
		else if (!wb_freeze)
			wb_rfaddrw <= ex_ctrl.rf_addrw;
	end

endmodule

// ==== src/id_decode.sv ====
`timescale 1ns/1ps
// decode-stage decoders on the latched instruction
// immediate extension, load/store op, branch target
// and the control word loaded into the execute register

module id_decode (
	input  insn_pkg::insn_t      id_insn,
	input  ctrl_pkg::branch_op_t id_branch_op,
	input  insn_pkg::pc_word_t   id_pc,
	input  logic                 hw_breakpoint,
	output insn_pkg::imm_t       id_simm,
	output ctrl_pkg::lsu_op_t    id_lsu_op,
	output insn_pkg::pc_word_t   id_branch_target,
	output ctrl_pkg::ex_ctrl_t   ex_ctrl_next
);
	import insn_pkg::*;
	import ctrl_pkg::*;

	opcode_t opc;
	logic    is_xsync;

	assign opc      = id_insn[OPC_HI:OPC_LO];
	assign is_xsync = (opc == OPC_XSYNC);

	////////////////////////////////////////////////////////////////////////////
	// immediate and load/store decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (opc)
			// spr number, zero extended
			OPC_MTSPR:
				id_simm = {16'b0, id_insn[25:21], id_insn[10:0]};
			// split store offset
			OPC_SW, OPC_SB, OPC_SH:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			OPC_ADDI, OPC_ADDIC, OPC_XORI, OPC_SFXXI,
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// logical immediates and the rest
			default:
				id_simm = {16'b0, id_insn[15:0]};
		endcase
	end

	always_comb begin
		case (opc)
			OPC_LWZ: id_lsu_op = LSUOP_LWZ;
			OPC_LWS: id_lsu_op = LSUOP_LWS;
			OPC_LBZ: id_lsu_op = LSUOP_LBZ;
			OPC_LBS: id_lsu_op = LSUOP_LBS;
			OPC_LHZ: id_lsu_op = LSUOP_LHZ;
			OPC_LHS: id_lsu_op = LSUOP_LHS;
			OPC_SW:  id_lsu_op = LSUOP_SW;
			OPC_SB:  id_lsu_op = LSUOP_SB;
			OPC_SH:  id_lsu_op = LSUOP_SH;
			default: id_lsu_op = LSUOP_NOP;
		endcase
	end

	// 26-bit word offset, pc relative
	assign id_branch_target = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc;

	////////////////////////////////////////////////////////////////////////////
	// execute control word
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ex_ctrl_next               = EX_CTRL_IDLE;
		ex_ctrl_next.alu_op2       = id_insn[9:6];
		ex_ctrl_next.comp_op       = id_insn[24:21];
		ex_ctrl_next.rf_addrw      = id_insn[RD_HI:RD_LO];
		ex_ctrl_next.simm          = id_simm;
		ex_ctrl_next.branch_target = id_branch_target;
		ex_ctrl_next.branch_op     = id_branch_op;
		ex_ctrl_next.spr_read      = (opc == OPC_MFSPR);
		ex_ctrl_next.spr_write     = (opc == OPC_MTSPR);
		// l.sys and l.trap share xsync, told apart by bits 25..23
		ex_ctrl_next.syscall       = is_xsync & (id_insn[25:23] == 3'b000);
		ex_ctrl_next.trap          = (is_xsync & (id_insn[25:23] == 3'b010)) | hw_breakpoint;

		case (opc)
			// return address goes to the link register
			OPC_JAL, OPC_JALR: begin
				ex_ctrl_next.rf_addrw = LINK_REG;
				ex_ctrl_next.rfwb_op  = RFWB_LR;
			end
			OPC_J, OPC_JR, OPC_BNF, OPC_BF, OPC_RFE, OPC_XSYNC,
			OPC_MTSPR, OPC_SW, OPC_SB, OPC_SH, OPC_NOP: begin
				// legal, nothing for the alu and no write-back
			end
			OPC_MOVHI: begin
				ex_ctrl_next.alu_op  = ALUOP_MOVHI;
				ex_ctrl_next.rfwb_op = RFWB_ALU;
			end
			OPC_ADDI: begin
				ex_ctrl_next.alu_op  = ALUOP_ADD;
				ex_ctrl_next.rfwb_op = RFWB_ALU;
			end
			OPC_ADDIC: begin
				ex_ctrl_next.alu_op  = ALUOP_ADDC;
				ex_ctrl_next.rfwb_op = RFWB_ALU;
			end
			OPC_ANDI: begin
				ex_ctrl_next.alu_op  = ALUOP_AND;
				ex_ctrl_next.rfwb_op = RFWB_ALU;
			end
			OPC_ORI: begin
				ex_ctrl_next.alu_op  = ALUOP_OR;
				ex_ctrl_next.rfwb_op = RFWB_ALU;
			end
			OPC_XORI: begin
				ex_ctrl_next.alu_op  = ALUOP_XOR;
				ex_ctrl_next.rfwb_op = RFWB_ALU;
			end
			OPC_MFSPR:
				ex_ctrl_next.rfwb_op = RFWB_SPRS;
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				ex_ctrl_next.rfwb_op = RFWB_LSU;
			// compares only set the flag
			OPC_SFXXI, OPC_SFXX:
				ex_ctrl_next.alu_op = ALUOP_COMP;
			OPC_ALU: begin
				ex_ctrl_next.alu_op  = {1'b0, id_insn[3:0]};
				ex_ctrl_next.rfwb_op = RFWB_ALU;
				// no divider and no find-first-one in this core
				ex_ctrl_next.illegal = (id_insn[4:0] == ALUOP_DIV) |
					(id_insn[4:0] == ALUOP_DIVU) | (id_insn[4:0] == ALUOP_FFL1);
			end
			// unknown opcode
			default:
				ex_ctrl_next.illegal = 1'b1;
		endcase
	end

endmodule

// ==== src/id_stage.sv ====
`timescale 1ns/1ps
// fetch-to-decode instruction latch and flush merge
// register file read addresses taken from the fetched word
// early branch op and immediate select, registered with the latch

module id_stage (
	input  logic                 clk,
	input  logic                 arst_n,
	input  insn_pkg::insn_t      if_insn,
	input  logic                 id_freeze,
	input  logic                 except_flush,
	input  logic                 pc_we,
	input  logic                 extend_flush,
	output logic                 pipe_flush,
	output insn_pkg::insn_t      id_insn,
	output ctrl_pkg::branch_op_t id_branch_op,
	output logic                 sel_imm,
	output insn_pkg::reg_addr_t  rf_addra,
	output insn_pkg::reg_addr_t  rf_addrb,
	output logic                 rf_rda,
	output logic                 rf_rdb
);
	import insn_pkg::*;
	import ctrl_pkg::*;

	opcode_t    if_opc;
	branch_op_t if_branch_op;
	logic       if_sel_imm;

	assign if_opc = if_insn[OPC_HI:OPC_LO];

	// exception, pc write or external request all empty the pipe
	assign pipe_flush = except_flush | pc_we | extend_flush;

	// read port addresses straight from fetch
	assign rf_addra = if_insn[RA_HI:RA_LO];
	assign rf_addrb = if_insn[RB_HI:RB_LO];
	// top two opcode bits flag use of ra and rb
	assign rf_rda = if_insn[31];
	assign rf_rdb = if_insn[30];

	////////////////////////////////////////////////////////////////////////////
	// early decode from the fetched word
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (if_opc)
			OPC_J, OPC_JAL:   if_branch_op = BRANCHOP_J;
			OPC_JR, OPC_JALR: if_branch_op = BRANCHOP_JR;
			OPC_BNF:          if_branch_op = BRANCHOP_BNF;
			OPC_BF:           if_branch_op = BRANCHOP_BF;
			OPC_RFE:          if_branch_op = BRANCHOP_RFE;
			default:          if_branch_op = BRANCHOP_NOP;
		endcase
	end

	// operand b from the register file for these, immediate for the rest
	always_comb begin
		case (if_opc)
			OPC_JALR, OPC_JR, OPC_RFE, OPC_MFSPR, OPC_MTSPR, OPC_XSYNC,
			OPC_SW, OPC_SB, OPC_SH, OPC_ALU, OPC_SFXX, OPC_NOP:
				if_sel_imm = 1'b0;
			default:
				if_sel_imm = 1'b1;
		endcase
	end

	// decode latch, flush wins over freeze
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_insn      <= NOP_INSN;
			id_branch_op <= BRANCHOP_NOP;
		end else if (pipe_flush) begin
			id_insn      <= NOP_INSN;
			id_branch_op <= BRANCHOP_NOP;
		end else if (!id_freeze) begin
			id_insn      <= if_insn;
			id_branch_op <= if_branch_op;
		end
	end

	// follows the latch, no flush term
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sel_imm <= 1'b0;
		else if (!id_freeze)
			sel_imm <= if_sel_imm;
	end

endmodule

// ==== src/insn_pkg.sv ====
// instruction word format of the core
// word and field types, field positions, opcode values
// the bubble word and the link register address

package insn_pkg;

	////////////////////////////////////////////////////////////////////////////
	// word and field types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] insn_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  reg_addr_t;
	// instruction address without the byte offset
	typedef logic [29:0] pc_word_t;
	typedef logic [31:0] imm_t;

	// field positions inside insn_t
	localparam int OPC_HI = 31;
	localparam int OPC_LO = 26;
	// destination
	localparam int RD_HI  = 25;
	localparam int RD_LO  = 21;
	// source a and b
	localparam int RA_HI  = 20;
	localparam int RA_LO  = 16;
	localparam int RB_HI  = 15;
	localparam int RB_LO  = 11;

	////////////////////////////////////////////////////////////////////////////
	// major opcodes
	////////////////////////////////////////////////////////////////////////////

	// jumps and branches
	localparam opcode_t OPC_J     = 6'h00;
	localparam opcode_t OPC_JAL   = 6'h01;
	localparam opcode_t OPC_BNF   = 6'h03;
	localparam opcode_t OPC_BF    = 6'h04;
	localparam opcode_t OPC_NOP   = 6'h05;
	localparam opcode_t OPC_MOVHI = 6'h06;
	// sys, trap and the sync group
	localparam opcode_t OPC_XSYNC = 6'h08;
	localparam opcode_t OPC_RFE   = 6'h09;
	localparam opcode_t OPC_JR    = 6'h11;
	localparam opcode_t OPC_JALR  = 6'h12;
	// loads
	localparam opcode_t OPC_LWZ   = 6'h21;
	localparam opcode_t OPC_LWS   = 6'h22;
	localparam opcode_t OPC_LBZ   = 6'h23;
	localparam opcode_t OPC_LBS   = 6'h24;
	localparam opcode_t OPC_LHZ   = 6'h25;
	localparam opcode_t OPC_LHS   = 6'h26;
	// alu with immediate
	localparam opcode_t OPC_ADDI  = 6'h27;
	localparam opcode_t OPC_ADDIC = 6'h28;
	localparam opcode_t OPC_ANDI  = 6'h29;
	localparam opcode_t OPC_ORI   = 6'h2a;
	localparam opcode_t OPC_XORI  = 6'h2b;
	localparam opcode_t OPC_MFSPR = 6'h2d;
	localparam opcode_t OPC_SFXXI = 6'h2f;
	localparam opcode_t OPC_MTSPR = 6'h30;
	// stores
	localparam opcode_t OPC_SW    = 6'h35;
	localparam opcode_t OPC_SB    = 6'h36;
	localparam opcode_t OPC_SH    = 6'h37;
	// register form alu and compare
	localparam opcode_t OPC_ALU   = 6'h38;
	localparam opcode_t OPC_SFXX  = 6'h39;

	// bubble: nop with bit 16 set marks the slot as void
	localparam insn_t NOP_INSN = {OPC_NOP, 26'h041_0000};

	// jal and jalr write their return address here
	localparam reg_addr_t LINK_REG = 5'd9;

endpackage

// ==== src/operand_select.sv ====
`timescale 1ns/1ps
// alu operand source select in the decode cycle
// immediate, execute forward, write-back forward or register file

module operand_select (
	input  insn_pkg::insn_t     id_insn,
	input  logic                sel_imm,
	input  ctrl_pkg::ex_ctrl_t  ex_ctrl,
	input  insn_pkg::reg_addr_t wb_rfaddrw,
	input  logic                wbforw_valid,
	output ctrl_pkg::sel_t      sel_a,
	output ctrl_pkg::sel_t      sel_b
);
	import insn_pkg::*;
	import ctrl_pkg::*;

	// forward pick for one source, the newer result first
	function automatic sel_t fwd_sel(input reg_addr_t src);
		if ((src == ex_ctrl.rf_addrw) && ex_ctrl.rfwb_op[0])
			return SEL_EX_FORW;
		else if ((src == wb_rfaddrw) && wbforw_valid)
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	assign sel_a = fwd_sel(id_insn[RA_HI:RA_LO]);

	// immediate beats any forward on operand b
	assign sel_b = sel_imm ? SEL_IMM : fwd_sel(id_insn[RB_HI:RB_LO]);

endmodule

// ==== verif/decode_model.svh ====
// reference model of the decode control pipeline
// legal opcode list, decoders for the fetched and the latched word
// operand source rule, decode, execute and write-back registers

opcode_t legal_opc [0:28] = '{
	OPC_J, OPC_JAL, OPC_JALR, OPC_JR, OPC_BNF, OPC_BF, OPC_RFE, OPC_MOVHI,
	OPC_MFSPR, OPC_MTSPR, OPC_XSYNC, OPC_NOP, OPC_LWZ, OPC_LWS, OPC_LBZ,
	OPC_LBS, OPC_LHZ, OPC_LHS, OPC_SW, OPC_SB, OPC_SH, OPC_ADDI, OPC_ADDIC,
	OPC_ANDI, OPC_ORI, OPC_XORI, OPC_SFXXI, OPC_SFXX, OPC_ALU
};

// expected register contents
insn_t      ref_id_insn;
branch_op_t ref_id_bop;
logic       ref_sel_imm;
ex_ctrl_t   ref_ex_ctrl;
insn_t      ref_ex_insn;
reg_addr_t  ref_wb_addr;

function automatic logic opcode_legal(input opcode_t o);
	foreach (legal_opc[i])
		if (legal_opc[i] == o)
			return 1'b1;
	return 1'b0;
endfunction

function automatic branch_op_t branch_op_of(input insn_t w);
	case (w[31:26])
		OPC_J, OPC_JAL:   return BRANCHOP_J;
		OPC_JR, OPC_JALR: return BRANCHOP_JR;
		OPC_BNF:          return BRANCHOP_BNF;
		OPC_BF:           return BRANCHOP_BF;
		OPC_RFE:          return BRANCHOP_RFE;
		default:          return BRANCHOP_NOP;
	endcase
endfunction

// operand b from the register file for these groups
function automatic logic uses_imm(input insn_t w);
	case (w[31:26])
		OPC_ALU, OPC_SFXX, OPC_JR, OPC_JALR, OPC_RFE, OPC_MFSPR, OPC_MTSPR,
		OPC_XSYNC, OPC_SW, OPC_SB, OPC_SH, OPC_NOP:
			return 1'b0;
		default:
			return 1'b1;
	endcase
endfunction

function automatic imm_t simm_of(input insn_t w);
	logic [15:0] split;
	split = {w[25:21], w[10:0]};
	case (w[31:26])
		OPC_MTSPR:
			return {16'h0000, split};
		OPC_SW, OPC_SB, OPC_SH:
			return {{16{split[15]}}, split};
		OPC_ADDI, OPC_ADDIC, OPC_XORI, OPC_SFXXI, OPC_LWZ, OPC_LWS, OPC_LBZ,
		OPC_LBS, OPC_LHZ, OPC_LHS:
			return {{16{w[15]}}, w[15:0]};
		default:
			return {16'h0000, w[15:0]};
	endcase
endfunction

function automatic lsu_op_t lsu_op_of(input insn_t w);
	case (w[31:26])
		OPC_LWZ: return LSUOP_LWZ;
		OPC_LWS: return LSUOP_LWS;
		OPC_LBZ: return LSUOP_LBZ;
		OPC_LBS: return LSUOP_LBS;
		OPC_LHZ: return LSUOP_LHZ;
		OPC_LHS: return LSUOP_LHS;
		OPC_SW:  return LSUOP_SW;
		OPC_SB:  return LSUOP_SB;
		OPC_SH:  return LSUOP_SH;
		default: return LSUOP_NOP;
	endcase
endfunction

// word offset in bits 25..0, signed
function automatic pc_word_t target_of(input insn_t w, input pc_word_t pc);
	pc_word_t offset;
	offset = w[25] ? {4'hf, w[25:0]} : {4'h0, w[25:0]};
	return pc + offset;
endfunction

function automatic ex_ctrl_t ctrl_word_of(input insn_t w, input branch_op_t bop,
		input pc_word_t pc, input logic bkpt);
	ex_ctrl_t c;
	opcode_t  o;
	o = w[31:26];
	c = EX_CTRL_IDLE;
	c.alu_op2 = w[9:6];
	c.comp_op = w[24:21];
	// jal and jalr link through r9
	c.rf_addrw = (o == OPC_JAL || o == OPC_JALR) ? LINK_REG : w[25:21];
	c.simm = simm_of(w);
	c.branch_target = target_of(w, pc);
	c.branch_op = bop;
	c.spr_read = (o == OPC_MFSPR);
	c.spr_write = (o == OPC_MTSPR);
	c.syscall = (o == OPC_XSYNC) && (w[25:23] == 3'b000);
	c.trap = ((o == OPC_XSYNC) && (w[25:23] == 3'b010)) || bkpt;
	case (o)
		OPC_MOVHI: c.alu_op = ALUOP_MOVHI;
		OPC_ADDI:  c.alu_op = ALUOP_ADD;
		OPC_ADDIC: c.alu_op = ALUOP_ADDC;
		OPC_ANDI:  c.alu_op = ALUOP_AND;
		OPC_ORI:   c.alu_op = ALUOP_OR;
		OPC_XORI:  c.alu_op = ALUOP_XOR;
		OPC_ALU:   c.alu_op = {1'b0, w[3:0]};
		OPC_SFXX, OPC_SFXXI: c.alu_op = ALUOP_COMP;
		default: ;
	endcase
	case (o)
		OPC_MOVHI, OPC_ADDI, OPC_ADDIC, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_ALU:
			c.rfwb_op = RFWB_ALU;
		OPC_JAL, OPC_JALR: c.rfwb_op = RFWB_LR;
		OPC_MFSPR:         c.rfwb_op = RFWB_SPRS;
		OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
			c.rfwb_op = RFWB_LSU;
		default: ;
	endcase
	// divide and find-first-one have no unit here
	c.illegal = !opcode_legal(o) || ((o == OPC_ALU) &&
		(w[4:0] == ALUOP_DIV || w[4:0] == ALUOP_DIVU || w[4:0] == ALUOP_FFL1));
	return c;
endfunction

// source pick, newest result first
function automatic sel_t operand_src(input reg_addr_t src, input logic imm);
	if (imm)
		return SEL_IMM;
	if (src == ref_ex_ctrl.rf_addrw && ref_ex_ctrl.rfwb_op[0])
		return SEL_EX_FORW;
	if (src == ref_wb_addr && wbforw_valid)
		return SEL_WB_FORW;
	return SEL_RF;
endfunction

task automatic pipe_reset();
	ref_id_insn = NOP_INSN;
	ref_id_bop = BRANCHOP_NOP;
	ref_sel_imm = 1'b0;
	ref_ex_ctrl = EX_CTRL_IDLE;
	ref_ex_insn = NOP_INSN;
	ref_wb_addr = '0;
endtask

// one rising edge, later stages first so they see the old values
task automatic pipe_advance();
	logic flush;
	flush = except_flush | pc_we | extend_flush;
	if (!wb_freeze)
		ref_wb_addr = ref_ex_ctrl.rf_addrw;
	if (flush || (id_freeze && !ex_freeze)) begin
		ref_ex_ctrl = EX_CTRL_IDLE;
		ref_ex_insn = NOP_INSN;
	end else if (!ex_freeze) begin
		ref_ex_ctrl = ctrl_word_of(ref_id_insn, ref_id_bop, id_pc, hw_breakpoint);
		ref_ex_insn = ref_id_insn;
	end
	if (!id_freeze)
		ref_sel_imm = uses_imm(if_insn);
	if (flush) begin
		ref_id_insn = NOP_INSN;
		ref_id_bop = BRANCHOP_NOP;
	end else if (!id_freeze) begin
		ref_id_insn = if_insn;
		ref_id_bop = branch_op_of(if_insn);
	end
endtask

// ==== verif/tb_decode_ctrl.sv ====
`timescale 1ns/1ps
// testbench for the decode control top level
// random and directed instruction streams checked against a reference model

module tb_decode_ctrl;
	import insn_pkg::*;
	import ctrl_pkg::*;

	localparam int RAND_CYCLES  = 400;
	localparam int STALL_CYCLES = 400;
	// three passes of eleven words plus two drain cycles
	localparam int FWD_CYCLES   = 39;
	localparam int CYCLE_LIMIT  = 2 * (2 + RAND_CYCLES + STALL_CYCLES + FWD_CYCLES) + 50;

	logic       clk = 1'b0;
	logic       arst_n;
	insn_t      if_insn;
	pc_word_t   id_pc;
	logic       id_freeze, ex_freeze, wb_freeze;
	logic       except_flush, pc_we, extend_flush;
	logic       hw_breakpoint, wbforw_valid;
	logic       flushpipe, rf_rda, rf_rdb;
	reg_addr_t  rf_addra, rf_addrb;
	insn_t      id_insn, ex_insn;
	imm_t       id_simm;
	lsu_op_t    id_lsu_op;
	branch_op_t id_branch_op;
	pc_word_t   id_branch_target;
	sel_t       sel_a, sel_b;
	ex_ctrl_t   ex_ctrl;

	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	insn_t fwd_seq [0:10];

	`include "decode_model.svh"

	decode_ctrl_top uut (.*);

	always #20 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////////

	function automatic insn_t make_insn(input opcode_t o, input int rd, input int ra,
			input int rb);
		return {o, 5'(rd), 5'(ra), 5'(rb), 11'h000};
	endfunction

	// mostly legal opcodes, one in eight from the unused map
	function automatic insn_t random_insn();
		opcode_t bad_opc [0:3];
		alu_op_t no_unit [0:2];
		opcode_t o;
		insn_t   w;
		bad_opc = '{6'h02, 6'h0a, 6'h1f, 6'h3f};
		no_unit = '{ALUOP_DIV, ALUOP_DIVU, ALUOP_FFL1};
		if (($urandom % 8) == 0)
			o = bad_opc[$urandom % 4];
		else
			o = legal_opc[$urandom % 29];
		w = {o, 26'($urandom)};
		// steer some xsync words to sys or trap
		if ((o == OPC_XSYNC) && (($urandom % 2) == 0))
			w[25:23] = (($urandom % 2) == 0) ? 3'b000 : 3'b010;
		// and some alu words to a sub-op with no unit
		if ((o == OPC_ALU) && (($urandom % 4) == 0))
			w[4:0] = no_unit[$urandom % 3];
		return w;
	endfunction

	task automatic drive_random(input logic stalls);
		if_insn = random_insn();
		id_pc = 30'($urandom);
		hw_breakpoint = ($urandom % 16) == 0;
		wbforw_valid = ($urandom % 8) == 0;
		id_freeze = stalls && (($urandom % 8) == 0);
		ex_freeze = stalls && (($urandom % 8) == 0);
		wb_freeze = stalls && (($urandom % 8) == 0);
		except_flush = stalls && (($urandom % 16) == 0);
		pc_we = stalls && (($urandom % 16) == 0);
		extend_flush = stalls && (($urandom % 16) == 0);
	endtask

	task automatic report_mismatch(input string test, input string sig,
			input logic [127:0] exp, input logic [127:0] act);
		$display("FAILED %s: %s expected %0h actual %0h", test, sig, exp, act);
		errors++;
		test_errors++;
	endtask

	// sampled at the falling edge, registers and inputs both settled
	task automatic check_outputs(input string test);
		logic [11:0] rd_exp;
		rd_exp = {if_insn[31:30], if_insn[20:16], if_insn[15:11]};
		checks += 11;
		if (flushpipe !== (except_flush | pc_we | extend_flush))
			report_mismatch(test, "flushpipe", except_flush | pc_we | extend_flush, flushpipe);
		if ({rf_rda, rf_rdb, rf_addra, rf_addrb} !== rd_exp)
			report_mismatch(test, "rf_read", rd_exp, {rf_rda, rf_rdb, rf_addra, rf_addrb});
		if (id_insn !== ref_id_insn)
			report_mismatch(test, "id_insn", ref_id_insn, id_insn);
		if (id_branch_op !== ref_id_bop)
			report_mismatch(test, "id_branch_op", ref_id_bop, id_branch_op);
		if (id_simm !== simm_of(ref_id_insn))
			report_mismatch(test, "id_simm", simm_of(ref_id_insn), id_simm);
		if (id_lsu_op !== lsu_op_of(ref_id_insn))
			report_mismatch(test, "id_lsu_op", lsu_op_of(ref_id_insn), id_lsu_op);
		if (id_branch_target !== target_of(ref_id_insn, id_pc))
			report_mismatch(test, "id_branch_target", target_of(ref_id_insn, id_pc),
				id_branch_target);
		if (sel_a !== operand_src(ref_id_insn[20:16], 1'b0))
			report_mismatch(test, "sel_a", operand_src(ref_id_insn[20:16], 1'b0), sel_a);
		if (sel_b !== operand_src(ref_id_insn[15:11], ref_sel_imm))
			report_mismatch(test, "sel_b", operand_src(ref_id_insn[15:11], ref_sel_imm), sel_b);
		if (ex_ctrl !== ref_ex_ctrl)
			report_mismatch(test, "ex_ctrl", ref_ex_ctrl, ex_ctrl);
		if (ex_insn !== ref_ex_insn)
			report_mismatch(test, "ex_insn", ref_ex_insn, ex_insn);
	endtask

	task automatic step(input string test);
		@(posedge clk);
		pipe_advance();
		@(negedge clk);
		check_outputs(test);
	endtask

	task automatic close_test(input string test);
		$display("test %s: %s, %0d errors", test, (test_errors == 0) ? "passed" : "failed",
			test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hab10_d895));
		arst_n = 1'b0;
		if_insn = NOP_INSN;
		id_pc = '0;
		drive_random(1'b0);
		if_insn = NOP_INSN;
		hw_breakpoint = 1'b0;
		wbforw_valid = 1'b0;
		pipe_reset();
		repeat (2) @(negedge clk);
		check_outputs("reset");
		close_test("reset");
		arst_n = 1'b1;

		for (int i = 0; i < RAND_CYCLES; i++) begin
			drive_random(1'b0);
			step("random_decode");
		end
		close_test("random_decode");

		// freezes and all three flush sources mixed in
		for (int i = 0; i < STALL_CYCLES; i++) begin
			drive_random(1'b1);
			step("stall_flush");
		end
		close_test("stall_flush");

		// back-to-back writers and readers of r1..r6 and the link register
		// r1 written twice in a row so execute and write-back both match
		// compare carries r6 in its write field with no write enable
		fwd_seq = '{make_insn(OPC_ADDI, 1, 2, 0), make_insn(OPC_ALU, 1, 1, 2),
			make_insn(OPC_ALU, 3, 1, 1), make_insn(OPC_LWZ, 2, 1, 0),
			make_insn(OPC_ALU, 3, 2, 1), make_insn(OPC_JAL, 0, 0, 0),
			make_insn(OPC_ALU, 4, 9, 9), make_insn(OPC_SW, 0, 4, 9),
			make_insn(OPC_ALU, 5, 4, 9), make_insn(OPC_SFXX, 6, 5, 4),
			make_insn(OPC_ALU, 6, 6, 5)};
		drive_random(1'b0);
		hw_breakpoint = 1'b0;
		for (int pass = 0; pass < 3; pass++) begin
			for (int i = 0; i < 13; i++) begin
				if_insn = (i < 11) ? fwd_seq[i] : NOP_INSN;
				id_pc = 30'($urandom);
				wbforw_valid = ((i + pass) % 2) == 1;
				step("forwarding");
			end
		end
		close_test("forwarding");

		$display("tests: %0d run, %0d failed; checks: %0d, errors: %0d", tests_run,
			tests_failed, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
